/* rv_alu_pkg.sv */
// ALU operation codes shared by the decode-facing ports, the ALU and the testbench
package rv_alu_pkg;

    // RV32I integer operations, as selected by decode
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLL  = 4'd5,   // Shift amount from the low bits of b
        SRL  = 4'd6,
        SRA  = 4'd7,   // Arithmetic, sign fills from the left
        SLT  = 4'd8,   // Signed compare, result is 0 or 1
        SLTU = 4'd9    // Unsigned compare
    } alu_op_e;

endpackage

/* rv_ctrl_pkg.sv */
// Control encodings for the execute stage: operand class, branch type and forwarding source
package rv_ctrl_pkg;

    // Steers the choice of ALU operands
    typedef enum logic [2:0] {
        LOAD_STORE = 3'b000,   // rs1 + imm
        BRANCH     = 3'b001,   // rs1 against rs2
        REG        = 3'b010,   // rs1 with rs2 or imm
        JAL        = 3'b011,   // pc + 4
        LUI        = 3'b100,   // imm + 0
        AUIPC      = 3'b101,   // pc + imm
        JALR       = 3'b111    // pc + 4
    } op_class_e;

    // Same values as funct3 of the B-type instructions
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_type_e;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,   // Value read by decode
        FWD_EX   = 2'd1,
        FWD_MEM  = 2'd2,
        FWD_WB   = 2'd3
    } fwd_sel_e;

endpackage

/* alu.sv */
// Combinational integer ALU, also giving the subtraction flags used for branch compares
module alu #(
    parameter int XLEN = 32
) (
    input  rv_alu_pkg::alu_op_e alu_op,
    input  logic [XLEN-1:0]     a,
    input  logic [XLEN-1:0]     b,
    output logic [XLEN-1:0]     result,
    output logic                zero,
    output logic                negative,
    output logic                borrow
);
    import rv_alu_pkg::*;

    localparam int SHW = $clog2(XLEN);

    logic [XLEN:0]  diff;    // One extra bit holds the borrow
    logic [SHW-1:0] shamt;

    assign diff  = {1'b0, a} - {1'b0, b};
    assign shamt = b[SHW-1:0];

    // Flags always come from a - b, whatever the operation
    assign zero     = (diff[XLEN-1:0] == '0);
    assign negative = diff[XLEN-1];
    assign borrow   = diff[XLEN];   // Set when a < b unsigned

    always_comb
    begin
        case (alu_op)
            ADD:     result = a + b;
            SUB:     result = diff[XLEN-1:0];
            AND:     result = a & b;
            OR:      result = a | b;
            XOR:     result = a ^ b;
            SLL:     result = a << shamt;
            SRL:     result = a >> shamt;
            SRA:     result = $signed(a) >>> shamt;
            SLT:     result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            SLTU:    result = {{(XLEN-1){1'b0}}, borrow};
            default: result = '0;
        endcase
    end

endmodule

/* forward_unit.sv */
// Picks the newest eligible producer for each source register of the incoming instruction
module forward_unit (
    input  logic [4:0]            rs1_addr,
    input  logic [4:0]            rs2_addr,
    input  logic                  ex_valid,
    input  logic                  ex_reg_write,
    input  logic                  ex_mem_read,
    input  logic [4:0]            ex_rd,
    input  logic                  mem_valid,
    input  logic                  mem_reg_write,
    input  logic                  mem_mem_read,
    input  logic [4:0]            mem_rd,
    input  logic                  wb_reg_write,
    input  logic [4:0]            wb_rd,
    output rv_ctrl_pkg::fwd_sel_e fwd_sel1,
    output rv_ctrl_pkg::fwd_sel_e fwd_sel2
);
    import rv_ctrl_pkg::*;

    logic ex_ok;
    logic mem_ok;
    logic wb_ok;

    // Load data only returns through writeback
    assign ex_ok  = ex_valid && ex_reg_write && !ex_mem_read && (ex_rd != 5'd0);
    assign mem_ok = mem_valid && mem_reg_write && !mem_mem_read && (mem_rd != 5'd0);
    assign wb_ok  = wb_reg_write && (wb_rd != 5'd0);

    // Newest producer wins
    always_comb
    begin
        if (ex_ok && ex_rd == rs1_addr)
            fwd_sel1 = FWD_EX;
        else if (mem_ok && mem_rd == rs1_addr)
            fwd_sel1 = FWD_MEM;
        else if (wb_ok && wb_rd == rs1_addr)
            fwd_sel1 = FWD_WB;
        else
            fwd_sel1 = FWD_NONE;
    end

    always_comb
    begin
        if (ex_ok && ex_rd == rs2_addr)
            fwd_sel2 = FWD_EX;
        else if (mem_ok && mem_rd == rs2_addr)
            fwd_sel2 = FWD_MEM;
        else if (wb_ok && wb_rd == rs2_addr)
            fwd_sel2 = FWD_WB;
        else
            fwd_sel2 = FWD_NONE;
    end

endmodule

/* branch_unit.sv */
// Branch and jump resolution: taken decision from the ALU flags and the target address
module branch_unit #(
    parameter int XLEN = 32
) (
    input  logic                      is_branch,
    input  logic                      is_jump,
    input  rv_ctrl_pkg::op_class_e    op_class,
    input  rv_ctrl_pkg::branch_type_e branch_type,
    input  logic                      zero,
    input  logic                      negative,
    input  logic                      borrow,
    input  logic                      overflow,
    input  logic [XLEN-1:0]           pc,
    input  logic [XLEN-1:0]           imm,
    input  logic [XLEN-1:0]           rs1,
    output logic                      taken,
    output logic [XLEN-1:0]           target
);
    import rv_ctrl_pkg::*;

    logic            cond;
    logic            signed_lt;
    logic [XLEN-1:0] jalr_sum;

    // Sign of the difference, corrected when the subtraction overflowed
    assign signed_lt = negative ^ overflow;

    always_comb
    begin
        case (branch_type)
            BEQ:     cond = zero;
            BNE:     cond = !zero;
            BLT:     cond = signed_lt;
            BGE:     cond = !signed_lt;
            BLTU:    cond = borrow;
            BGEU:    cond = !borrow;
            default: cond = 1'b0;
        endcase
    end

    assign taken = is_jump || (is_branch && cond);   // Jumps always go

    assign jalr_sum = rs1 + imm;
    assign target   = (op_class == JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : pc + imm;

endmodule

/* execute.sv */
// Execute stage: captures the decoded instruction with forwarded operands, then runs ALU and branch
module execute #(
    parameter int XLEN = 32
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      id_valid,
    input  logic [XLEN-1:0]           pc,
    input  logic [4:0]                rs1_addr,
    input  logic [4:0]                rs2_addr,
    input  logic [XLEN-1:0]           rs1_value,
    input  logic [XLEN-1:0]           rs2_value,
    input  logic [XLEN-1:0]           imm,
    input  rv_ctrl_pkg::op_class_e    op_class,
    input  rv_alu_pkg::alu_op_e       alu_op,
    input  logic                      alu_src,
    input  rv_ctrl_pkg::branch_type_e branch_type,
    input  logic                      is_branch,
    input  logic                      is_jump,
    input  logic [4:0]                rd,
    input  logic                      reg_write,
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  logic                      mem_to_reg,
    input  logic                      wb_reg_write,
    input  logic [4:0]                wb_rd,
    input  logic [XLEN-1:0]           wb_data,
    input  logic                      mem_valid,
    input  logic                      mem_reg_write,
    input  logic                      mem_mem_read,
    input  logic [4:0]                mem_rd,
    input  logic [XLEN-1:0]           mem_alu_result,
    output logic                      ex_valid,
    output logic [XLEN-1:0]           ex_alu_result,
    output logic [XLEN-1:0]           ex_store_data,
    output logic [4:0]                ex_rd,
    output logic                      ex_reg_write,
    output logic                      ex_mem_read,
    output logic                      ex_mem_write,
    output logic                      ex_mem_to_reg,
    output logic                      ex_pc_src,
    output logic [XLEN-1:0]           ex_branch_target
);
    import rv_alu_pkg::*;
    import rv_ctrl_pkg::*;

    fwd_sel_e        fwd_sel1;
    fwd_sel_e        fwd_sel2;
    logic [XLEN-1:0] rs1_fwd;
    logic [XLEN-1:0] rs2_fwd;

    // Stage register payload
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] rs1_q;
    logic [XLEN-1:0] rs2_q;
    logic [XLEN-1:0] imm_q;
    op_class_e       op_class_q;
    alu_op_e         alu_op_q;
    logic            alu_src_q;
    branch_type_e    branch_type_q;
    logic            is_branch_q;
    logic            is_jump_q;

    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    alu_op_e         alu_op_sel;
    logic            zero;
    logic            negative;
    logic            borrow;
    logic            overflow;

    function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel, input logic [XLEN-1:0] ex_val,
                                                input logic [XLEN-1:0] mem_val,
                                                input logic [XLEN-1:0] wb_val,
                                                input logic [XLEN-1:0] reg_val);
        case (sel)
            FWD_EX:  return ex_val;
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    forward_unit forward_unit_i (
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .ex_valid      (ex_valid),
        .ex_reg_write  (ex_reg_write),
        .ex_mem_read   (ex_mem_read),
        .ex_rd         (ex_rd),
        .mem_valid     (mem_valid),
        .mem_reg_write (mem_reg_write),
        .mem_mem_read  (mem_mem_read),
        .mem_rd        (mem_rd),
        .wb_reg_write  (wb_reg_write),
        .wb_rd         (wb_rd),
        .fwd_sel1      (fwd_sel1),
        .fwd_sel2      (fwd_sel2)
    );

    // ex_alu_result is the instruction now in execute, one ahead of the incoming one
    always_comb
    begin
        rs1_fwd = fwd_mux(fwd_sel1, ex_alu_result, mem_alu_result, wb_data, rs1_value);
        rs2_fwd = fwd_mux(fwd_sel2, ex_alu_result, mem_alu_result, wb_data, rs2_value);
    end

    // Controls drop to a bubble when nothing is issued
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ex_valid      <= 1'b0;
            ex_reg_write  <= 1'b0;
            ex_mem_read   <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            is_branch_q   <= 1'b0;
            is_jump_q     <= 1'b0;
        end
        else if (!stall)
        begin
            ex_valid      <= id_valid;
            ex_reg_write  <= id_valid && reg_write;
            ex_mem_read   <= id_valid && mem_read;
            ex_mem_write  <= id_valid && mem_write;
            ex_mem_to_reg <= id_valid && mem_to_reg;
            is_branch_q   <= id_valid && is_branch;
            is_jump_q     <= id_valid && is_jump;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            pc_q          <= pc;
            rs1_q         <= rs1_fwd;
            rs2_q         <= rs2_fwd;
            imm_q         <= imm;
            op_class_q    <= op_class;
            alu_op_q      <= alu_op;
            alu_src_q     <= alu_src;
            branch_type_q <= branch_type;
            ex_rd         <= rd;
        end
    end

    // Operand choice by instruction class
    always_comb
    begin
        case (op_class_q)
            LOAD_STORE:
            begin
                alu_a = rs1_q;
                alu_b = imm_q;
            end
            BRANCH:
            begin
                alu_a = rs1_q;
                alu_b = rs2_q;
            end
            REG:
            begin
                alu_a = rs1_q;
                alu_b = alu_src_q ? imm_q : rs2_q;
            end
            LUI:
            begin
                alu_a = imm_q;
                alu_b = '0;
            end
            AUIPC:
            begin
                alu_a = pc_q;
                alu_b = imm_q;
            end
            JAL, JALR:
            begin
                alu_a = pc_q;   // Link value
                alu_b = XLEN'(4);
            end
            default:
            begin
                alu_a = '0;
                alu_b = '0;
            end
        endcase
    end

    // Only REG and BRANCH take decode's operation, the rest are sums
    always_comb
    begin
        if (op_class_q == REG || op_class_q == BRANCH)
            alu_op_sel = alu_op_q;
        else
            alu_op_sel = ADD;
    end

    alu #(.XLEN(XLEN)) alu_i (
        .alu_op   (alu_op_sel),
        .a        (alu_a),
        .b        (alu_b),
        .result   (ex_alu_result),
        .zero     (zero),
        .negative (negative),
        .borrow   (borrow)
    );

    // Signed overflow of a - b
    assign overflow = (alu_a[XLEN-1] != alu_b[XLEN-1]) && (negative != alu_a[XLEN-1]);

    branch_unit #(.XLEN(XLEN)) branch_unit_i (
        .is_branch   (is_branch_q),
        .is_jump     (is_jump_q),
        .op_class    (op_class_q),
        .branch_type (branch_type_q),
        .zero        (zero),
        .negative    (negative),
        .borrow      (borrow),
        .overflow    (overflow),
        .pc          (pc_q),
        .imm         (imm_q),
        .rs1         (rs1_q),
        .taken       (ex_pc_src),
        .target      (ex_branch_target)
    );

    assign ex_store_data = rs2_q;

endmodule

/* ex_mem_reg.sv */
// Execute/memory pipeline register, held on stall, with controls cleared in empty slots
module ex_mem_reg #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            ex_valid,
    input  logic [XLEN-1:0] ex_alu_result,
    input  logic [XLEN-1:0] ex_store_data,
    input  logic [4:0]      ex_rd,
    input  logic            ex_reg_write,
    input  logic            ex_mem_read,
    input  logic            ex_mem_write,
    input  logic            ex_mem_to_reg,
    input  logic            ex_pc_src,
    input  logic [XLEN-1:0] ex_branch_target,
    output logic            mem_valid,
    output logic [XLEN-1:0] mem_alu_result,
    output logic [XLEN-1:0] mem_store_data,
    output logic [4:0]      mem_rd,
    output logic            mem_reg_write,
    output logic            mem_mem_read,
    output logic            mem_mem_write,
    output logic            mem_mem_to_reg,
    output logic            mem_pc_src,
    output logic [XLEN-1:0] mem_branch_target
);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mem_valid      <= 1'b0;
            mem_reg_write  <= 1'b0;
            mem_mem_read   <= 1'b0;
            mem_mem_write  <= 1'b0;
            mem_mem_to_reg <= 1'b0;
            mem_pc_src     <= 1'b0;
        end
        else if (!stall)
        begin
            // Memory stage never sees a stray control in a bubble
            mem_valid      <= ex_valid;
            mem_reg_write  <= ex_valid && ex_reg_write;
            mem_mem_read   <= ex_valid && ex_mem_read;
            mem_mem_write  <= ex_valid && ex_mem_write;
            mem_mem_to_reg <= ex_valid && ex_mem_to_reg;
            mem_pc_src     <= ex_valid && ex_pc_src;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
        begin
            mem_alu_result    <= ex_alu_result;
            mem_store_data    <= ex_store_data;
            mem_rd            <= ex_rd;
            mem_branch_target <= ex_branch_target;
        end
    end

endmodule

/* ex_pipeline.sv */
// Top of the execute subsystem: execute stage and ex/mem register, with forwarding feedback
module ex_pipeline #(
    parameter int XLEN = 32
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      id_valid,
    input  logic [XLEN-1:0]           pc,
    input  logic [4:0]                rs1_addr,
    input  logic [4:0]                rs2_addr,
    input  logic [XLEN-1:0]           rs1_value,
    input  logic [XLEN-1:0]           rs2_value,
    input  logic [XLEN-1:0]           imm,
    input  rv_ctrl_pkg::op_class_e    op_class,
    input  rv_alu_pkg::alu_op_e       alu_op,
    input  logic                      alu_src,
    input  rv_ctrl_pkg::branch_type_e branch_type,
    input  logic                      is_branch,
    input  logic                      is_jump,
    input  logic [4:0]                rd,
    input  logic                      reg_write,
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  logic                      mem_to_reg,
    input  logic                      wb_reg_write,
    input  logic [4:0]                wb_rd,
    input  logic [XLEN-1:0]           wb_data,
    output logic                      mem_valid,
    output logic [XLEN-1:0]           mem_alu_result,
    output logic [XLEN-1:0]           mem_store_data,
    output logic [4:0]                mem_rd,
    output logic                      mem_reg_write,
    output logic                      mem_mem_read,
    output logic                      mem_mem_write,
    output logic                      mem_mem_to_reg,
    output logic                      mem_pc_src,
    output logic [XLEN-1:0]           mem_branch_target
);

    logic            ex_valid;
    logic [XLEN-1:0] ex_alu_result;
    logic [XLEN-1:0] ex_store_data;
    logic [4:0]      ex_rd;
    logic            ex_reg_write;
    logic            ex_mem_read;
    logic            ex_mem_write;
    logic            ex_mem_to_reg;
    logic            ex_pc_src;
    logic [XLEN-1:0] ex_branch_target;

    // mem_ outputs also return to execute as a forwarding source
    execute #(.XLEN(XLEN)) execute_i (.*);

    ex_mem_reg #(.XLEN(XLEN)) ex_mem_reg_i (.*);

endmodule

/* ex_asserts.sv */
// Concurrent checks on the execute subsystem's memory-side outputs, bound into ex_pipeline
module ex_asserts #(
    parameter int XLEN = 32
) (
    input logic            clk,
    input logic            rst,
    input logic            stall,
    input logic            mem_valid,
    input logic [XLEN-1:0] mem_alu_result,
    input logic [XLEN-1:0] mem_store_data,
    input logic [4:0]      mem_rd,
    input logic            mem_reg_write,
    input logic            mem_mem_read,
    input logic            mem_mem_write,
    input logic            mem_mem_to_reg,
    input logic            mem_pc_src,
    input logic [XLEN-1:0] mem_branch_target
);

    pc_src_needs_valid: assert property (@(posedge clk) disable iff (rst)
        mem_pc_src |-> mem_valid)
        else $error("mem_pc_src high in an empty slot");

    // Other controls are clear in bubbles too
    bubble_clean: assert property (@(posedge clk) disable iff (rst)
        !mem_valid |-> !(mem_reg_write || mem_mem_read || mem_mem_write || mem_mem_to_reg))
        else $error("control output high while mem_valid is low");

    hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable({mem_valid, mem_alu_result, mem_store_data, mem_rd,
                           mem_reg_write, mem_mem_read, mem_mem_write, mem_mem_to_reg,
                           mem_pc_src, mem_branch_target}))
        else $error("mem outputs changed during a stall");

endmodule

bind ex_pipeline ex_asserts #(.XLEN(XLEN)) ex_asserts_i (.*);

/* tb_ex_pipeline.sv */
// Directed testbench for ex_pipeline: reference model, expected-result queue and test tasks
module tb_ex_pipeline;
    import rv_alu_pkg::*;
    import rv_ctrl_pkg::*;

    logic clk, rst, stall, id_valid, alu_src, is_branch, is_jump;
    logic [31:0] pc, rs1_value, rs2_value, imm, wb_data;
    logic [4:0] rs1_addr, rs2_addr, rd, wb_rd;
    op_class_e op_class;
    alu_op_e alu_op;
    branch_type_e branch_type;
    logic reg_write, mem_read, mem_write, mem_to_reg, wb_reg_write;
    logic mem_valid, mem_reg_write, mem_mem_read, mem_mem_write, mem_mem_to_reg, mem_pc_src;
    logic [31:0] mem_alu_result, mem_store_data, mem_branch_target;
    logic [4:0] mem_rd;

    logic [31:0] regs [32];   // Architectural register model
    logic [31:0] rng;
    logic [31:0] exp_res[$], exp_store[$], exp_tgt[$];
    logic [4:0] exp_rd[$];
    logic [4:0] exp_flags[$];   // {mem_write, check target, pc_src, mem_read, reg_write}
    int acc_cyc[$], acc_st[$];
    int cyc, stall_cnt;
    logic fresh;
    logic wb_rw_n;
    logic [4:0] wb_rd_n;
    logic [31:0] wb_data_n;

    ex_pipeline #(.XLEN(32)) dut_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic [31:0] alu_ref(alu_op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return $signed(a) >>> b[4:0];
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return (a < b) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic logic cond_ref(branch_type_e bt, logic [31:0] a, logic [31:0] b);
        case (bt)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            BGE:     return $signed(a) >= $signed(b);
            BLTU:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Monitor at negedge, where every output is settled
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (fresh && mem_valid)
            begin
                assert (exp_res.size() > 0)
                else
                begin
                    $display("Result appeared with no instruction outstanding at t=%0t", $time);
                    stop_run();
                end
                check_val("latency", cyc - acc_cyc[0] - (stall_cnt - acc_st[0]), 2);
                check_val("mem_alu_result", mem_alu_result, exp_res[0]);
                check_val("mem_store_data", mem_store_data, exp_store[0]);
                check_val("mem_rd", mem_rd, exp_rd[0]);
                check_val("mem_reg_write", mem_reg_write, exp_flags[0][0]);
                check_val("mem_mem_read", mem_mem_read, exp_flags[0][1]);
                check_val("mem_mem_to_reg", mem_mem_to_reg, exp_flags[0][1]);
                check_val("mem_pc_src", mem_pc_src, exp_flags[0][2]);
                check_val("mem_mem_write", mem_mem_write, exp_flags[0][4]);
                if (exp_flags[0][3])
                    check_val("mem_branch_target", mem_branch_target, exp_tgt[0]);
                void'(exp_res.pop_front());
                void'(exp_store.pop_front());
                void'(exp_tgt.pop_front());
                void'(exp_rd.pop_front());
                void'(exp_flags.pop_front());
                void'(acc_cyc.pop_front());
                void'(acc_st.pop_front());
            end
            if (id_valid && !stall)   // Accepted at the coming edge
            begin
                acc_cyc.push_back(cyc);
                acc_st.push_back(stall_cnt);
            end
            if (stall)
                stall_cnt++;
            fresh = !stall;
            cyc++;
        end
    end

    task automatic set_wb(input logic [4:0] d, input logic [31:0] data, input logic upd);
        wb_rw_n = 1'b1;
        wb_rd_n = d;
        wb_data_n = data;
        if (upd && d != 0)
            regs[d] = data;
    endtask

    task automatic drive_wb();
        wb_reg_write <= wb_rw_n;
        wb_rd <= wb_rd_n;
        wb_data <= wb_data_n;
        wb_rw_n = 1'b0;
    endtask

    task automatic issue(input op_class_e cls, input alu_op_e op, input logic src,
                         input logic [4:0] r1, input logic [4:0] r2,
                         input logic [31:0] v1, input logic [31:0] v2,
                         input logic [31:0] im, input logic [31:0] p,
                         input branch_type_e bt, input logic isb, input logic isj,
                         input logic [4:0] d, input logic rw, input logic mr);
        logic [31:0] fa, fb, res, tgt;
        logic tk;
        logic mw;
        fa = regs[r1];
        fb = regs[r2];
        case (cls)
            LOAD_STORE: res = fa + im;
            BRANCH:     res = alu_ref(op, fa, fb);
            REG:        res = alu_ref(op, fa, src ? im : fb);
            LUI:        res = im;
            AUIPC:      res = p + im;
            default:    res = p + 32'd4;
        endcase
        tk = isj || (isb && cond_ref(bt, fa, fb));
        tgt = (cls == JALR) ? ((fa + im) & ~32'd1) : p + im;
        mw = (cls == LOAD_STORE) && !mr;   // Memory access without a load is a store
        exp_res.push_back(res);
        exp_store.push_back(fb);
        exp_tgt.push_back(tgt);
        exp_rd.push_back(d);
        exp_flags.push_back({mw, isb || isj, tk, mr, rw});
        if (rw && !mr && d != 0)
            regs[d] = res;
        @(posedge clk);
        id_valid <= 1'b1;
        op_class <= cls;
        alu_op <= op;
        alu_src <= src;
        rs1_addr <= r1;
        rs2_addr <= r2;
        rs1_value <= v1;
        rs2_value <= v2;
        imm <= im;
        pc <= p;
        branch_type <= bt;
        is_branch <= isb;
        is_jump <= isj;
        rd <= d;
        reg_write <= rw;
        mem_read <= mr;
        mem_write <= mw;
        mem_to_reg <= mr;
        drive_wb();
    endtask

    // REG-class instruction; stale bits make decode supply outdated rs1 and rs2 values
    task automatic alu_instr(input alu_op_e op, input logic src, input logic [4:0] r1,
                             input logic [4:0] r2, input logic [31:0] im, input logic [4:0] d,
                             input logic rw, input logic [1:0] stale);
        logic [31:0] junk;
        junk = 32'h5a5a_0f0f;
        issue(REG, op, src, r1, r2, regs[r1] ^ (stale[0] ? junk : 32'd0),
              regs[r2] ^ (stale[1] ? junk : 32'd0), im, 32'h100, BEQ, 0, 0, d, rw, 0);
    endtask

    task automatic idle();
        @(posedge clk);
        id_valid <= 1'b0;
        drive_wb();
    endtask

    task automatic drain();
        int cnt;
        cnt = 0;
        idle();
        while (exp_res.size() > 0 || acc_cyc.size() > 0)
        begin
            @(negedge clk);
            cnt++;
            if (cnt > 60)
            begin
                $display("Timed out waiting for %0d outstanding results", exp_res.size());
                stop_run();
            end
        end
    endtask

    task automatic test_reset();
        repeat (3)
        begin
            @(negedge clk);
            check_val("mem_valid", mem_valid, 0);
            check_val("controls", {mem_reg_write, mem_mem_read, mem_mem_write,
                                   mem_mem_to_reg, mem_pc_src}, 0);
        end
    endtask

    task automatic test_alu();
        alu_op_e op;
        for (int i = 0; i < 10; i++)
        begin
            op = alu_op_e'(i);
            alu_instr(op, 0, 5'(next_rand() % 31 + 1), 5'(next_rand() % 31 + 1), next_rand(),
                      9, 0, 0);
            alu_instr(op, 1, 5'(next_rand() % 31 + 1), 0, next_rand(), 9, 0, 0);
        end
        issue(LUI, ADD, 0, 0, 0, 0, 0, next_rand() & 32'hffff_f000, 32'h40, BEQ, 0, 0, 9, 0, 0);
        issue(AUIPC, ADD, 0, 0, 0, 0, 0, next_rand() & 32'hffff_f000, 32'h1234, BEQ, 0, 0,
              9, 0, 0);
        drain();
    endtask

    task automatic test_forward();
        alu_instr(ADD, 1, 1, 0, next_rand(), 3, 1, 0);
        alu_instr(XOR, 0, 3, 2, 0, 8, 1, 2'b01);      // From execute
        drain();
        alu_instr(ADD, 1, 2, 0, next_rand(), 4, 1, 0);
        idle();
        alu_instr(SUB, 0, 4, 1, 0, 8, 1, 2'b01);      // From ex_mem_reg
        drain();
        set_wb(5, next_rand(), 1);
        alu_instr(OR, 0, 5, 0, 0, 8, 1, 2'b01);       // From writeback
        drain();
        alu_instr(ADD, 1, 1, 0, 32'h77, 0, 1, 0);     // Writes x0, ignored
        alu_instr(ADD, 0, 0, 0, 0, 8, 1, 0);
        issue(LOAD_STORE, ADD, 1, 2, 0, regs[2], 0, 32'h10, 32'h0, BEQ, 0, 0, 6, 1, 1);
        alu_instr(ADD, 0, 6, 0, 0, 8, 1, 0);          // Load result is not forwarded
        issue(LOAD_STORE, ADD, 1, 7, 8, regs[7], ~regs[8], 32'h24, 32'h0, BEQ, 0, 0,
              0, 0, 0);                               // Store data from execute
        drain();
        alu_instr(ADD, 1, 3, 0, next_rand(), 1, 1, 0);
        alu_instr(ADD, 1, 4, 0, next_rand(), 2, 1, 0);
        set_wb(1, 32'hbad0_0001, 0);                  // Older than ex_mem_reg copy
        alu_instr(SUB, 0, 1, 2, 0, 8, 1, 2'b11);
        drain();
    endtask

    task automatic test_branch();
        logic [31:0] pa [5], pb [5];
        pa = '{32'd5, 32'hffff_fffd, 32'd3, 32'h8000_0000, 32'h7fff_ffff};
        pb = '{32'd5, 32'd4, 32'hffff_fff0, 32'h0000_0001, 32'h8000_0000};
        foreach (pa[j])
        begin
            regs[10] = pa[j];
            regs[11] = pb[j];
            for (int k = 0; k < 6; k++)   // BEQ and BNE, then funct3 codes 4 to 7
                issue(BRANCH, SUB, 0, 10, 11, pa[j], pb[j], next_rand() & 32'h0000_fffe,
                      next_rand() & 32'hffff_fffc, branch_type_e'(k < 2 ? k : k + 2),
                      1, 0, 0, 0, 0);
            drain();
        end
    endtask

    task automatic test_jump();
        issue(JAL, ADD, 0, 0, 0, 0, 0, 32'h0000_0ff0, 32'h2000, BEQ, 0, 1, 1, 1, 0);
        alu_instr(ADD, 1, 0, 0, next_rand() & ~32'd1, 12, 1, 0);   // Even base, odd offset
        issue(JALR, ADD, 0, 12, 0, 32'h0, 0, 32'h35, 32'h3000, BEQ, 0, 1, 1, 1, 0);
        drain();
    endtask

    task automatic test_stall();
        int k;
        for (int i = 0; i < 12; i++)
        begin
            alu_instr(alu_op_e'(next_rand() % 10), 0, 5'(next_rand() % 31 + 1),
                      5'(next_rand() % 31 + 1), 0, 5'(next_rand() % 31 + 1), 1, 0);
            if (next_rand() % 2)
            begin
                k = next_rand() % 4 + 1;
                repeat (k)
                begin
                    @(posedge clk);
                    id_valid <= 1'b0;
                    stall <= 1'b1;
                end
                @(posedge clk);
                stall <= 1'b0;
            end
        end
        drain();
    endtask

    initial
    begin
        rng = 32'd62455;
        cyc = 0;
        stall_cnt = 0;
        fresh = 1'b0;
        wb_rw_n = 1'b0;
        wb_rd_n = '0;
        wb_data_n = '0;
        rst = 1'b1;
        stall = 1'b0;
        id_valid = 1'b0;
        pc = '0;
        rs1_addr = '0;
        rs2_addr = '0;
        rs1_value = '0;
        rs2_value = '0;
        imm = '0;
        op_class = REG;
        alu_op = ADD;
        alu_src = 1'b0;
        branch_type = BEQ;
        is_branch = 1'b0;
        is_jump = 1'b0;
        rd = '0;
        reg_write = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_to_reg = 1'b0;
        wb_reg_write = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        regs[0] = '0;
        for (int i = 1; i < 32; i++)
            regs[i] = next_rand();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_alu();
        test_forward();
        test_branch();
        test_jump();
        test_stall();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* all.f */
rv_alu_pkg.sv
rv_ctrl_pkg.sv
alu.sv
forward_unit.sv
branch_unit.sv
execute.sv
ex_mem_reg.sv
ex_pipeline.sv
ex_asserts.sv
tb_ex_pipeline.sv

/* Bender.yml */
package:
  name: ex_pipeline

sources:
  - rv_alu_pkg.sv
  - rv_ctrl_pkg.sv
  - alu.sv
  - forward_unit.sv
  - branch_unit.sv
  - execute.sv
  - ex_mem_reg.sv
  - ex_pipeline.sv
  - target: test
    files:
      - ex_asserts.sv
      - tb_ex_pipeline.sv
